// File: Makefile
# every source the simulator binary is built from
SRCS = $(wildcard design/*.sv testbench/*.sv testbench/*.svh)

all: run

obj_dir/Vzclock_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module zclock_tb -f compile.f

run: obj_dir/Vzclock_tb
	./obj_dir/Vzclock_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: compile.f
+incdir+testbench
design/zclk_pkg.sv
design/slot_timer.sv
design/io_wait_gen.sv
design/zclock.sv
design/zclock_top.sv
testbench/zclock_assert.sv
testbench/zclock_tb.sv

// File: design/io_wait_gen.sv
`timescale 1ns/1ps

module io_wait_gen (
	input  logic             fclk,
	input  logic             rst_n,
	input  logic             iorq_n,
	input  logic             m1_n,
	input  logic             external_port,
	input  logic             zpos,
	input  zclk_pkg::turbo_t int_turbo,
	output logic             io_wait
);

	import zclk_pkg::*;

	// io cycle to an external port, m1 excluded so intack is ignored
	logic       io;
	// io condition as seen at the previous zpos
	logic       io_r;
	logic       io_start;
	// bit 3 marks a running stretch, bits 2:0 are the pattern step
	logic [3:0] step;

	assign io = ~iorq_n & m1_n & external_port;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_r <= 1'b0;
		else if (zpos)
			io_r <= io;
	end

	// rising edge of io on a z80 clock edge, only in 14 MHz mode
	assign io_start = io & ~io_r & zpos & turbo_is_14(int_turbo);

	// load step 0 with the run flag, then walk 8 steps
	// overflow from 4'b1111 clears the run flag
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			step <= 4'd0;
		else if (io_start)
			step <= 4'b1000;
		else if (step[3])
			step <= step + 4'd1;
	end

	// pattern output one cycle behind the step counter
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wait <= 1'b0;
		end
		else
		begin
			if (step[3])
				io_wait <= IO_WAIT_PATTERN[step[2:0]];
			else
				io_wait <= 1'b0;
		end
	end

endmodule

// File: design/slot_timer.sv
`timescale 1ns/1ps

module slot_timer #(
	// fclk cycles per 7 MHz period, even and at least 4
	parameter int SLOT_LEN = 4
) (
	input  logic fclk,
	input  logic rst_n,
	output logic cbeg,
	output logic pre_cend
);

	localparam int CW = $clog2(SLOT_LEN);

	// wrap point and half-period point of the slot counter
	localparam logic [CW-1:0] LAST = CW'(SLOT_LEN - 1);
	localparam logic [CW-1:0] HALF = CW'(SLOT_LEN / 2);

	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_nxt;

	// free-running modulo SLOT_LEN
	always_comb
	begin
		if (cnt == LAST)
			cnt_nxt = '0;
		else
			cnt_nxt = cnt + 1'b1;
	end

	// counter parks at the last step in reset
	// so the first clock afterwards lands on 0
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= LAST;
		else
			cnt <= cnt_nxt;
	end

	// strobes registered against the next count
	// cbeg is high exactly while cnt is 0, pre_cend while cnt is HALF
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cbeg     <= 1'b0;
			pre_cend <= 1'b0;
		end
		else
		begin
			cbeg     <= (cnt_nxt == '0);
			pre_cend <= (cnt_nxt == HALF);
		end
	end

endmodule

// File: design/zclk_pkg.sv
package zclk_pkg;

	// z80 speed mode as requested by the cpu side and as latched on rfsh
	//   2'b00  3.5 MHz
	//   2'b01  7 MHz
	//   2'b1x  14 MHz, lower bit ignored
	typedef logic [1:0] turbo_t;

	localparam turbo_t TURBO_35 = 2'b00;
	localparam turbo_t TURBO_7  = 2'b01;
	localparam turbo_t TURBO_14 = 2'b10;

	// 14 MHz is flagged by the upper bit alone
	function automatic logic turbo_is_14(input turbo_t mode);
		return mode[1];
	endfunction

	// wait level per step of the external io stretch in 14 MHz mode
	// entry k applies while the step counter is at step k
	// the pattern holds the clock for five cycles, then lets single
	// half-periods through so the io cycle runs at roughly 7 MHz pace
	localparam logic IO_WAIT_PATTERN [0:7] = '{
		1'b1,
		1'b1,
		1'b1,
		1'b1,
		1'b1,
		1'b0,
		1'b1,
		1'b0
	};

endpackage

// File: design/zclock.sv
`timescale 1ns/1ps

module zclock (
	input  logic             fclk,
	input  logic             rst_n,
	input  logic             rfsh_n,
	input  zclk_pkg::turbo_t turbo,
	input  logic             mem_stall,
	input  logic             io_wait,
	input  logic             cbeg,
	input  logic             pre_cend,
	output logic             zclk_out,
	output logic             zpos,
	output logic             zneg,
	output zclk_pkg::turbo_t int_turbo
);

	import zclk_pkg::*;

	// rfsh_n as sampled on the previous zpos
	logic old_rfsh_n;
	// any reason to hold the z80 clock
	logic stall;
	// free-running half-rate toggle for 14 MHz
	logic clk14_src;
	// selects which pre_cend feeds zpos or zneg at 3.5 MHz
	logic precend_cnt;
	logic h_precend_1;
	logic h_precend_2;
	// phase sources for the active mode
	logic pre_zpos;
	logic pre_zneg;

	// mode switch only at the start of refresh
	// so the cpu never sees a clock change mid-fetch
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			old_rfsh_n <= 1'b1;
			int_turbo  <= TURBO_35;
		end
		else if (zpos)
		begin
			old_rfsh_n <= rfsh_n;
			if (old_rfsh_n && !rfsh_n)
				int_turbo <= turbo;
		end
	end

	assign stall = mem_stall | io_wait;

	// 14 MHz source, frozen while stalled
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	// halve pre_cend for 3.5 MHz
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			precend_cnt <= 1'b0;
		else if (pre_cend)
			precend_cnt <= ~precend_cnt;
	end

	// odd pulses go to zneg, even ones to zpos
	assign h_precend_1 = precend_cnt & pre_cend;
	assign h_precend_2 = ~precend_cnt & pre_cend;

	// phase source mux
	// at 7 MHz pre_cend gives the rising edge and cbeg the falling one
	always_comb
	begin
		if (turbo_is_14(int_turbo))
		begin
			pre_zpos = clk14_src;
			pre_zneg = ~clk14_src;
		end
		else if (int_turbo == TURBO_7)
		begin
			pre_zpos = pre_cend;
			pre_zneg = cbeg;
		end
		else
		begin
			pre_zpos = h_precend_2;
			pre_zneg = h_precend_1;
		end
	end

	// edge strobes, one cycle after the source
	// zpos only while the clock is high, zneg only while low,
	// which keeps the two strictly alternating
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= ~stall & pre_zpos & zclk_out;
			zneg <= ~stall & pre_zneg & ~zclk_out;
		end
	end

	// z80 clock pin, inverted again off-chip
	// updated half an fclk ahead of the strobes' next posedge
	always_ff @(negedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zclk_out <= 1'b0;
		end
		else
		begin
			if (zpos)
				zclk_out <= 1'b0;
			if (zneg)
				zclk_out <= 1'b1;
		end
	end

endmodule

// File: design/zclock_top.sv
`timescale 1ns/1ps

module zclock_top #(
	// fclk cycles per 7 MHz slot
	parameter int SLOT_LEN = 4
) (
	input  logic             fclk,
	input  logic             rst_n,
	input  zclk_pkg::turbo_t turbo,
	input  logic             rfsh_n,
	input  logic             iorq_n,
	input  logic             m1_n,
	input  logic             external_port,
	input  logic             mem_stall,
	output logic             zclk_out,
	output logic             zpos,
	output logic             zneg,
	output zclk_pkg::turbo_t int_turbo
);

	// 7 MHz slot strobes, stand-in for the arbiter timing
	logic cbeg;
	logic pre_cend;
	// extra stall from external io in 14 MHz mode
	logic io_wait;

	slot_timer #(
		.SLOT_LEN(SLOT_LEN)
	) i_slot_timer (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.cbeg     (cbeg),
		.pre_cend (pre_cend)
	);

	// samples on zpos and mode from the clock core
	io_wait_gen i_io_wait_gen (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.zpos          (zpos),
		.int_turbo     (int_turbo),
		.io_wait       (io_wait)
	);

	zclock i_zclock (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.rfsh_n    (rfsh_n),
		.turbo     (turbo),
		.mem_stall (mem_stall),
		.io_wait   (io_wait),
		.cbeg      (cbeg),
		.pre_cend  (pre_cend),
		.zclk_out  (zclk_out),
		.zpos      (zpos),
		.zneg      (zneg),
		.int_turbo (int_turbo)
	);

endmodule

// File: testbench/zclock_assert.sv
`timescale 1ns/1ps

module zclock_assert (
	input logic fclk,
	input logic rst_n,
	input logic stall,
	input logic zpos,
	input logic zneg
);

	// the two edge strobes never coincide
	strobes_exclusive: assert property (
		@(posedge fclk) disable iff (!rst_n) !(zpos && zneg)
	) else $error("zpos and zneg high in the same cycle");

	// a stalled cycle withholds both strobes one edge later
	stall_blocks_strobes: assert property (
		@(posedge fclk) disable iff (!rst_n) stall |=> (!zpos && !zneg)
	) else $error("strobe issued in the cycle after a stall");

endmodule

bind zclock zclock_assert i_zclock_assert (
	.fclk  (fclk),
	.rst_n (rst_n),
	.stall (stall),
	.zpos  (zpos),
	.zneg  (zneg)
);

// File: testbench/zclock_tb_model.svh
// cycle model of the clock subsystem, stepped on each rising fclk edge

// io wait level per step, bit k is step k
localparam logic [7:0] WAIT_STEPS = 8'b0101_1111;

int         m_slot;
logic       m_cbeg;
logic       m_pre_cend;
// which half of the 3.5 MHz period the next pre_cend serves
logic       m_half;
logic       m_toggle;
logic       m_zpos;
logic       m_zneg;
logic       m_zclk;
logic [1:0] m_mode;
logic       m_rfsh_prev;
logic       m_io_prev;
logic       m_wait_run;
logic [2:0] m_wait_step;
logic       m_io_wait;
// count of io stretches started, for stimulus sanity
int         m_io_starts = 0;

task automatic model_reset();
	m_slot      = SLOT_LEN - 1;
	m_cbeg      = 1'b0;
	m_pre_cend  = 1'b0;
	m_half      = 1'b0;
	m_toggle    = 1'b0;
	m_zpos      = 1'b0;
	m_zneg      = 1'b0;
	m_zclk      = 1'b0;
	m_mode      = 2'b00;
	m_rfsh_prev = 1'b1;
	m_io_prev   = 1'b0;
	m_wait_run  = 1'b0;
	m_wait_step = 3'd0;
	m_io_wait   = 1'b0;
endtask

// all next values are formed from the state before this edge
task automatic model_rise(input logic [1:0] t_req, input logic rfsh, input logic iorq,
	input logic m1, input logic ext, input logic mstall);
	logic stall;
	logic io;
	logic start;
	logic src_pos;
	logic src_neg;
	stall = mstall | m_io_wait;
	io    = !iorq && m1 && ext;
	start = io && !m_io_prev && m_zpos && m_mode[1];
	// phase sources for the mode in force before the edge
	if (m_mode[1])
	begin
		src_pos = m_toggle;
		src_neg = !m_toggle;
	end
	else if (m_mode == 2'b01)
	begin
		src_pos = m_pre_cend;
		src_neg = m_cbeg;
	end
	else
	begin
		src_pos = m_pre_cend && !m_half;
		src_neg = m_pre_cend && m_half;
	end
	// wait level trails the step by one cycle
	m_io_wait = m_wait_run ? WAIT_STEPS[m_wait_step] : 1'b0;
	if (start)
	begin
		m_wait_run  = 1'b1;
		m_wait_step = 3'd0;
		m_io_starts++;
	end
	else if (m_wait_run)
	begin
		if (m_wait_step == 3'd7)
			m_wait_run = 1'b0;
		else
			m_wait_step = m_wait_step + 3'd1;
	end
	// zpos samples the io condition and the refresh edge
	if (m_zpos)
	begin
		m_io_prev = io;
		if (m_rfsh_prev && !rfsh)
			m_mode = t_req;
		m_rfsh_prev = rfsh;
	end
	if (!stall)
		m_toggle = !m_toggle;
	if (m_pre_cend)
		m_half = !m_half;
	m_zpos = !stall && src_pos && m_zclk;
	m_zneg = !stall && src_neg && !m_zclk;
	m_slot = (m_slot + 1) % SLOT_LEN;
	m_cbeg = (m_slot == 0);
	m_pre_cend = (m_slot == SLOT_LEN / 2);
endtask

// z80 clock level moves on the falling edge
task automatic model_fall();
	if (m_zpos)
		m_zclk = 1'b0;
	if (m_zneg)
		m_zclk = 1'b1;
endtask

// File: testbench/zclock_tb.sv
`timescale 1ns/1ps

module zclock_tb;

	import zclk_pkg::*;

	// same slot length as handed to the DUT
	localparam int SLOT_LEN = 4;
	// the tests run for about 4000 cycles
	localparam int TIMEOUT_CYCLES = 6000;

	logic        fclk = 1'b0;
	logic        rst_n;
	turbo_t      turbo;
	logic        rfsh_n;
	logic        iorq_n;
	logic        m1_n;
	logic        external_port;
	logic        mem_stall;
	logic        zclk_out;
	logic        zpos;
	logic        zneg;
	turbo_t      int_turbo;

	integer      seed = 32'hd402_12f3;
	logic [31:0] rnd;
	int          cycle_cnt = 0;
	int          err_count = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	// strobe spacing monitor runs only while gap_period is nonzero
	int          gap_period = 0;
	int          last_pos;
	int          last_neg;
	int          last_kind;
	int          pos_pulses;

	`include "zclock_tb_model.svh"

	zclock_top #(
		.SLOT_LEN(SLOT_LEN)
	) i_dut (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.turbo         (turbo),
		.rfsh_n        (rfsh_n),
		.iorq_n        (iorq_n),
		.m1_n          (m1_n),
		.external_port (external_port),
		.mem_stall     (mem_stall),
		.zclk_out      (zclk_out),
		.zpos          (zpos),
		.zneg          (zneg),
		.int_turbo     (int_turbo)
	);

	// 4 ns fclk
	always #2 fclk = ~fclk;

	always @(posedge fclk)
		cycle_cnt = cycle_cnt + 1;

	initial
	begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d fclk cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic report_mismatch(input string what, input int got, input int expected);
		$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		err_count++;
	endtask

	// outputs have settled 1 ns after the rising edge
	// zclk_out holds the level set on the last falling edge
	task automatic compare_outputs();
		if (zpos !== m_zpos)
			report_mismatch("zpos", int'(zpos), int'(m_zpos));
		if (zneg !== m_zneg)
			report_mismatch("zneg", int'(zneg), int'(m_zneg));
		if (zclk_out !== m_zclk)
			report_mismatch("zclk_out", int'(zclk_out), int'(m_zclk));
		if (int_turbo !== m_mode)
			report_mismatch("int_turbo", int'(int_turbo), int'(m_mode));
	endtask

	task automatic track_gaps();
		if (gap_period != 0 && zpos)
		begin
			if (last_kind == 1)
			begin
				$display("At %0t two zpos strobes came without a zneg between them", $time);
				err_count++;
			end
			if (last_pos >= 0 && cycle_cnt - last_pos != gap_period)
				report_mismatch("zpos spacing", cycle_cnt - last_pos, gap_period);
			if (last_neg >= 0 && cycle_cnt - last_neg != gap_period / 2)
				report_mismatch("zneg to zpos distance", cycle_cnt - last_neg, gap_period / 2);
			last_pos = cycle_cnt;
			last_kind = 1;
			pos_pulses++;
		end
		if (gap_period != 0 && zneg)
		begin
			if (last_kind == 2)
			begin
				$display("At %0t two zneg strobes came without a zpos between them", $time);
				err_count++;
			end
			if (last_pos >= 0 && cycle_cnt - last_pos != gap_period / 2)
				report_mismatch("zpos to zneg distance", cycle_cnt - last_pos, gap_period / 2);
			last_neg = cycle_cnt;
			last_kind = 2;
		end
	endtask

	// model steps on the rising edge and the compare waits for the DUT to settle
	always @(posedge fclk)
	begin
		if (!rst_n)
			model_reset();
		else
			model_rise(turbo, rfsh_n, iorq_n, m1_n, external_port, mem_stall);
		#1;
		compare_outputs();
		track_gaps();
	end

	always @(negedge fclk)
		model_fall();

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	task automatic wait_zpos(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 64)
		begin
			@(negedge fclk);
			n++;
			if (zpos)
				seen = 1'b1;
		end
	endtask

	// refresh goes high over one zpos and low over the next
	task automatic set_mode(input turbo_t target);
		logic seen_hi;
		logic seen_lo;
		turbo  = target;
		rfsh_n = 1'b1;
		wait_zpos(seen_hi);
		@(negedge fclk);
		rfsh_n = 1'b0;
		wait_zpos(seen_lo);
		@(negedge fclk);
		rfsh_n = 1'b1;
		if (!seen_hi || !seen_lo)
		begin
			$display("Mode switch to %b found no zpos strobe to latch on", target);
			err_count++;
		end
		else if (int_turbo !== target)
			report_mismatch("int_turbo after mode switch", int'(int_turbo), int'(target));
	endtask

	// alternating idle gaps and io accesses of random length
	task automatic io_traffic(input int cycles);
		int left;
		int i;
		left = 0;
		for (i = 0; i < cycles; i++)
		begin
			@(negedge fclk);
			if (left == 0)
			begin
				rnd = $random(seed);
				if (iorq_n)
				begin
					iorq_n        = 1'b0;
					m1_n          = (rnd[1:0] != 2'b00);
					external_port = (rnd[3:2] != 2'b00);
					left          = 4 + int'(rnd[7:4]);
				end
				else
				begin
					iorq_n = 1'b1;
					left   = 2 + int'(rnd[7:4]);
				end
			end
			else
				left--;
		end
		iorq_n = 1'b1;
	endtask

	task automatic check_spacing(input int period, input int cycles, input logic with_io);
		// let the new mode settle first
		repeat (16) @(negedge fclk);
		last_pos   = -1;
		last_neg   = -1;
		last_kind  = 0;
		pos_pulses = 0;
		gap_period = period;
		if (with_io)
			io_traffic(cycles);
		else
			repeat (cycles) @(negedge fclk);
		gap_period = 0;
		if (pos_pulses < cycles / period - 1)
		begin
			$display("Only %0d zpos strobes in %0d cycles at period %0d", pos_pulses, cycles,
				period);
			err_count++;
		end
	endtask

	initial
	begin
		int     errs;
		int     n;
		int     changes;
		int     burst;
		int     pulses;
		int     starts;
		logic   seen;
		turbo_t prev_mode;
		rst_n         = 1'b0;
		turbo         = 2'b00;
		rfsh_n        = 1'b1;
		iorq_n        = 1'b1;
		m1_n          = 1'b1;
		external_port = 1'b0;
		mem_stall     = 1'b0;

		// reset values hold until the first strobe
		errs = err_count;
		repeat (8) @(negedge fclk);
		rst_n = 1'b1;
		seen = 1'b0;
		n = 0;
		while (!seen && n < 64)
		begin
			@(negedge fclk);
			n++;
			if (zpos || zneg)
				seen = 1'b1;
			else if (zclk_out !== 1'b0)
				report_mismatch("zclk_out before first strobe", int'(zclk_out), 0);
			if (!seen && int_turbo !== 2'b00)
				report_mismatch("int_turbo before first strobe", int'(int_turbo), 0);
		end
		if (!seen)
		begin
			$display("No zpos or zneg strobe within 64 cycles after reset");
			err_count++;
		end
		finish_test("reset state", errs);

		// random mode requests against random refresh levels
		errs = err_count;
		changes = 0;
		prev_mode = int_turbo;
		repeat (1000)
		begin
			@(negedge fclk);
			if (int_turbo !== prev_mode)
				changes++;
			prev_mode = int_turbo;
			rnd = $random(seed);
			turbo = rnd[1:0];
			if (rnd[3:2] == 2'b00)
				rfsh_n = ~rfsh_n;
		end
		if (changes == 0)
		begin
			$display("int_turbo never changed under random refresh cycles");
			err_count++;
		end
		finish_test("mode latch on refresh", errs);

		// strobe spacing in each mode without stalls
		errs = err_count;
		set_mode(2'b00);
		check_spacing(2 * SLOT_LEN, 96, 1'b0);
		set_mode(2'b01);
		check_spacing(SLOT_LEN, 96, 1'b0);
		set_mode(2'b10);
		check_spacing(2, 96, 1'b0);
		finish_test("strobe spacing per mode", errs);

		// memory stall bursts at 14 MHz
		errs = err_count;
		set_mode(2'b10);
		burst = 0;
		pulses = 0;
		repeat (900)
		begin
			@(negedge fclk);
			if (zpos)
				pulses++;
			rnd = $random(seed);
			if (burst > 0)
			begin
				mem_stall = 1'b1;
				burst--;
			end
			else if (rnd[2:0] == 3'b000)
			begin
				mem_stall = 1'b1;
				burst = int'(rnd[5:3]);
			end
			else
				mem_stall = 1'b0;
		end
		@(negedge fclk);
		mem_stall = 1'b0;
		if (pulses == 0)
		begin
			$display("No zpos strobe got through between the stall bursts");
			err_count++;
		end
		finish_test("memory stall at 14 MHz", errs);

		// external io stretches only at 14 MHz
		errs = err_count;
		set_mode(2'b10);
		starts = m_io_starts;
		io_traffic(700);
		if (m_io_starts == starts)
		begin
			$display("No external io access started a wait pattern at 14 MHz");
			err_count++;
		end
		set_mode(2'b01);
		check_spacing(SLOT_LEN, 250, 1'b1);
		set_mode(2'b00);
		check_spacing(2 * SLOT_LEN, 250, 1'b1);
		finish_test("external io wait", errs);

		$display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
